// File: src.f
exu_pkg.sv
exu_if.sv
exu_decode.sv
exu_execute.sv
exu_result.sv
exu_top.sv
tb_clkgen.sv
tb_exu.sv

// File: Makefile
SRCS := $(shell cat src.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_exu: src.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ps -f src.f --top-module tb_exu -o Vtb_exu

run: obj_dir/Vtb_exu
	./obj_dir/Vtb_exu | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_exu.sv
/*
 * Testbench for the integer execute stage
 * Directed tests for ALU, bypass, branches, external flush, back-pressure
 * and latency against a reference model of the stage rules
 */

module tb_exu;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int TEST_CYCLES = 500;              // Rough length of all tests

   logic                clk;
   logic                rst_n;
   logic                i_issue_valid;
   exu_pkg::alu_op_e    i_issue_op;
   exu_pkg::tag_t       i_issue_tag;
   exu_pkg::pc_t        i_issue_pc;
   exu_pkg::boff_t      i_issue_boff;
   logic                i_issue_pred_taken;
   exu_pkg::src_sel_e   i_rs1_sel;
   exu_pkg::src_sel_e   i_rs2_sel;
   exu_pkg::word_t      i_gpr_rs1;
   exu_pkg::word_t      i_gpr_rs2;
   exu_pkg::word_t      i_imm;
   exu_pkg::word_t      i_wb_data;
   logic                i_flush_lower;
   exu_pkg::pc_t        i_flush_path;
   logic                i_res_credit;
   logic                o_res_valid;
   exu_pkg::word_t      o_res_data;
   exu_pkg::tag_t       o_res_tag;
   exu_pkg::credit_t    o_issue_credit;
   logic                o_flush;
   exu_pkg::pc_t        o_flush_path;

   int                  n_checks;
   int                  n_errors;
   int                  credits;                  // Issue credits held
   int                  pending_credit;           // Result credits to hand back
   int                  n_res;
   bit                  auto_credit;
   logic [31:0]         lcg_state;
   exu_pkg::tag_t       next_tag;
   exu_pkg::tag_t       last_tag;
   time                 issue_time;
   time                 last_res_time;
   exu_pkg::word_t      exp_data_q[$];
   exu_pkg::tag_t       exp_tag_q[$];

   tb_clkgen i_clkgen (.o_clk(clk), .o_rst_n(rst_n));

   exu_top i_dut (
      .i_clk(clk), .i_rst_n(rst_n),
      .i_issue_valid(i_issue_valid), .i_issue_op(i_issue_op),
      .i_issue_tag(i_issue_tag), .i_issue_pc(i_issue_pc),
      .i_issue_boff(i_issue_boff), .i_issue_pred_taken(i_issue_pred_taken),
      .i_rs1_sel(i_rs1_sel), .i_rs2_sel(i_rs2_sel),
      .i_gpr_rs1(i_gpr_rs1), .i_gpr_rs2(i_gpr_rs2), .i_imm(i_imm),
      .i_wb_data(i_wb_data), .i_flush_lower(i_flush_lower),
      .i_flush_path(i_flush_path), .o_res_valid(o_res_valid),
      .o_res_data(o_res_data), .o_res_tag(o_res_tag),
      .o_issue_credit(o_issue_credit), .i_res_credit(i_res_credit),
      .o_flush(o_flush), .o_flush_path(o_flush_path)
   );

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // Reference ALU per operation rule
   function automatic exu_pkg::word_t alu_result(exu_pkg::alu_op_e op,
                                                 exu_pkg::word_t a, exu_pkg::word_t b);
      case (op)
         exu_pkg::ADD:  return a + b;
         exu_pkg::SUB:  return a - b;
         exu_pkg::AND:  return a & b;
         exu_pkg::OR:   return a | b;
         exu_pkg::XOR:  return a ^ b;
         exu_pkg::SLL:  return a << b[4:0];
         exu_pkg::SRL:  return a >> b[4:0];
         exu_pkg::SRA:  return $signed(a) >>> b[4:0];
         exu_pkg::SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         exu_pkg::SLTU: return (a < b) ? 32'd1 : 32'd0;
         default:       return '0;
      endcase
   endfunction

   function automatic logic branch_taken(exu_pkg::alu_op_e op,
                                         exu_pkg::word_t a, exu_pkg::word_t b);
      case (op)
         exu_pkg::BEQ: return a == b;
         exu_pkg::BNE: return a != b;
         exu_pkg::BLT: return $signed(a) < $signed(b);
         exu_pkg::BGE: return $signed(a) >= $signed(b);
         default:      return 1'b1;               // JAL
      endcase
   endfunction

   task automatic check_word(exu_pkg::word_t got, exu_pkg::tag_t got_tag,
                             exu_pkg::word_t exp, exu_pkg::tag_t exp_tag);
      n_checks++;
      if (got !== exp || got_tag !== exp_tag) begin
         n_errors++;
         $display("CHECK FAILED at %0t: result %h tag %0d, expected %h tag %0d",
                  $time, got, got_tag, exp, exp_tag);
      end
   endtask

   task automatic check_flush(logic got, exu_pkg::pc_t got_path,
                              logic exp, exu_pkg::pc_t exp_path);
      n_checks++;
      if (got !== exp || (exp && got_path !== exp_path)) begin
         n_errors++;
         $display("CHECK FAILED at %0t: flush %b path %h, expected %b path %h",
                  $time, got, got_path, exp, exp_path);
      end
   endtask

   task automatic check_credit(exu_pkg::credit_t got, exu_pkg::credit_t exp, string what);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   // Result monitor samples on the falling edge where outputs are stable
   always @(negedge clk) begin
      if (rst_n) begin
         credits = credits + int'(o_issue_credit);
         if (o_res_valid) begin
            n_res++;
            last_res_time = $time;
            pending_credit += int'(auto_credit);
            if (exp_data_q.size() == 0) begin
               n_errors++;
               $display("Unexpected result %h with tag %0d at %0t",
                        o_res_data, o_res_tag, $time);
            end else begin
               check_word(o_res_data, o_res_tag, exp_data_q.pop_front(),
                          exp_tag_q.pop_front());
            end
         end
      end
   end

   // Consumer hands back one result credit per cycle
   always @(posedge clk) begin
      #1;
      if (pending_credit > 0) begin
         i_res_credit = 1'b1;
         pending_credit--;
      end else begin
         i_res_credit = 1'b0;
      end
   end

   task automatic issue(exu_pkg::alu_op_e op, exu_pkg::src_sel_e s1, exu_pkg::src_sel_e s2,
                        exu_pkg::word_t a, exu_pkg::word_t b, exu_pkg::pc_t pc,
                        exu_pkg::boff_t boff, logic pred);
      @(posedge clk);
      #1;
      i_issue_valid = 1'b0;
      while (credits == 0) begin                  // Issuer stalls without a credit
         @(posedge clk);
         #1;
      end
      i_issue_valid      = 1'b1;
      i_issue_op         = op;
      i_issue_tag        = next_tag;
      i_issue_pc         = pc;
      i_issue_boff       = boff;
      i_issue_pred_taken = pred;
      i_rs1_sel          = s1;
      i_rs2_sel          = s2;
      i_gpr_rs1          = a;
      i_gpr_rs2          = b;
      i_imm              = b;
      credits--;
      last_tag   = next_tag;
      next_tag   = next_tag + 1'b1;
      issue_time = $time + 7;                     // Sampling edge
   endtask

   task automatic expect_result(exu_pkg::word_t data);
      exp_data_q.push_back(data);
      exp_tag_q.push_back(last_tag);
   endtask

   task automatic idle(int n);
      repeat (n) begin
         @(posedge clk);
         #1;
         i_issue_valid = 1'b0;
      end
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      idle(1);
      while (exp_data_q.size() != 0 && waited < 60) begin
         idle(1);
         waited++;
      end
      if (exp_data_q.size() != 0) begin
         n_errors++;
         $display("%0d results never arrived by %0t", exp_data_q.size(), $time);
         exp_data_q.delete();
         exp_tag_q.delete();
      end
      idle(4);
      check_credit(exu_pkg::credit_t'(credits), exu_pkg::credit_t'(exu_pkg::ISSUE_CREDITS),
                   "issue credits held");
   endtask

   task automatic alu_ops();
      exu_pkg::word_t a;
      exu_pkg::word_t b;
      exu_pkg::alu_op_e op;
      for (int i = 0; i < 20; i++) begin
         op = exu_pkg::alu_op_e'(i % 10);
         a  = lcg_next();
         b  = lcg_next();
         issue(op, exu_pkg::GPR, (i % 2) ? exu_pkg::IMM : exu_pkg::GPR, a, b, '0, '0, 1'b0);
         expect_result(alu_result(op, a, b));
      end
      wait_drain();
   endtask

   task automatic bypass_chain();
      exu_pkg::word_t a;
      exu_pkg::word_t b;
      exu_pkg::word_t c;
      exu_pkg::word_t w;
      a = lcg_next();
      b = lcg_next();
      c = lcg_next();
      issue(exu_pkg::ADD, exu_pkg::GPR, exu_pkg::GPR, a, b, '0, '0, 1'b0);
      expect_result(a + b);
      issue(exu_pkg::SUB, exu_pkg::BYP_X, exu_pkg::GPR, 32'hdead_beef, c, '0, '0, 1'b0);
      expect_result(a + b - c);
      issue(exu_pkg::XOR, exu_pkg::GPR, exu_pkg::GPR, a, c, '0, '0, 1'b0);
      expect_result(a ^ c);
      issue(exu_pkg::OR, exu_pkg::GPR, exu_pkg::GPR, b, c, '0, '0, 1'b0);
      expect_result(b | c);
      issue(exu_pkg::ADD, exu_pkg::BYP_R, exu_pkg::IMM, 32'h0bad_cafe, 32'd5, '0, '0, 1'b0);
      expect_result((a ^ c) + 32'd5);
      w = lcg_next();
      i_wb_data = w;
      issue(exu_pkg::AND, exu_pkg::GPR, exu_pkg::BYP_WB, a, 32'h1234_5678, '0, '0, 1'b0);
      expect_result(a & w);
      wait_drain();
   endtask

   task automatic branch_resolve();
      exu_pkg::alu_op_e op;
      exu_pkg::word_t a;
      exu_pkg::word_t b;
      exu_pkg::pc_t pc;
      exu_pkg::boff_t boff;
      exu_pkg::pc_t next;
      logic taken;
      logic misp;
      for (int i = 0; i < 20; i++) begin
         op    = exu_pkg::alu_op_e'(10 + (i % 5));
         a     = lcg_next();
         b     = (i % 4 < 2) ? a : lcg_next();
         pc    = exu_pkg::pc_t'(lcg_next());
         boff  = exu_pkg::boff_t'(lcg_next());
         misp  = (i / 5) % 2;
         taken = branch_taken(op, a, b);
         next  = taken ? pc + exu_pkg::pc_t'($signed(boff)) : pc + 31'd2;
         issue(op, exu_pkg::GPR, exu_pkg::GPR, a, b, pc, boff, taken ^ misp);
         expect_result((op == exu_pkg::JAL) ? {pc + 31'd2, 1'b0} : {next, 1'b0});
         issue(exu_pkg::ADD, exu_pkg::GPR, exu_pkg::GPR, a, 32'd1, '0, '0, 1'b0);
         if (!misp) begin
            expect_result(a + 32'd1);
         end
         // Sampled at the closing edge of the flush cycle
         issue(exu_pkg::XOR, exu_pkg::GPR, exu_pkg::GPR, a, b, '0, '0, 1'b0);
         if (!misp) begin
            expect_result(a ^ b);
         end
         @(negedge clk);
         check_flush(o_flush, o_flush_path, misp, next);
         wait_drain();
      end
   endtask

   task automatic external_flush();
      exu_pkg::pc_t ext_path;
      ext_path = exu_pkg::pc_t'(lcg_next());
      // Lower flush kills a mispredicting JAL and the ADD behind it
      issue(exu_pkg::JAL, exu_pkg::GPR, exu_pkg::GPR, '0, '0, 31'h100, 12'h20, 1'b0);
      issue(exu_pkg::ADD, exu_pkg::GPR, exu_pkg::GPR, 32'd3, 32'd4, '0, '0, 1'b0);
      @(posedge clk);
      #1;
      i_issue_valid = 1'b0;
      i_flush_lower = 1'b1;
      i_flush_path  = ext_path;
      @(negedge clk);
      check_flush(o_flush, o_flush_path, 1'b1, ext_path);
      @(posedge clk);
      #1;
      i_flush_lower = 1'b0;
      wait_drain();
   endtask

   task automatic back_pressure();
      int base;
      auto_credit = 1'b0;
      base = n_res;
      for (int i = 0; i < 6; i++) begin
         issue(exu_pkg::ADD, exu_pkg::GPR, exu_pkg::IMM, 32'(i), 32'd100, '0, '0, 1'b0);
         expect_result(32'(i) + 32'd100);
         if (i == 3) begin
            idle(10);
            check_credit(exu_pkg::credit_t'(n_res - base),
                         exu_pkg::credit_t'(exu_pkg::RESULT_CREDITS), "results seen");
            check_credit(exu_pkg::credit_t'(credits),
                         exu_pkg::credit_t'(exu_pkg::RESULT_CREDITS), "issue credits held");
         end
      end
      idle(10);
      check_credit(exu_pkg::credit_t'(n_res - base),
                   exu_pkg::credit_t'(exu_pkg::RESULT_CREDITS), "results seen");
      check_credit(exu_pkg::credit_t'(credits), '0, "issue credits held");
      auto_credit = 1'b1;
      pending_credit += exu_pkg::RESULT_CREDITS;  // Consumer catches up
      wait_drain();
   endtask

   task automatic issue_latency();
      issue(exu_pkg::SUB, exu_pkg::GPR, exu_pkg::GPR, 32'd50, 32'd8, '0, '0, 1'b0);
      expect_result(32'd42);
      wait_drain();
      check_credit(exu_pkg::credit_t'((last_res_time - issue_time + 4) / 8), 3'd3,
                   "cycles from issue to result");
   endtask

   initial begin
      n_checks = 0;
      n_errors = 0;
      credits = exu_pkg::ISSUE_CREDITS;
      pending_credit = 0;
      n_res = 0;
      auto_credit = 1'b1;
      lcg_state = 32'hccbd;
      next_tag = '0;
      last_tag = '0;
      i_issue_valid = 1'b0;
      i_issue_op = exu_pkg::ADD;
      i_issue_tag = '0;
      i_issue_pc = '0;
      i_issue_boff = '0;
      i_issue_pred_taken = 1'b0;
      i_rs1_sel = exu_pkg::GPR;
      i_rs2_sel = exu_pkg::GPR;
      i_gpr_rs1 = '0;
      i_gpr_rs2 = '0;
      i_imm = '0;
      i_wb_data = '0;
      i_flush_lower = 1'b0;
      i_flush_path = '0;
      i_res_credit = 1'b0;
      @(posedge rst_n);
      idle(2);
      @(negedge clk);
      check_flush(o_flush, o_flush_path, 1'b0, '0);
      check_credit(o_issue_credit, '0, "credit return after reset");
      issue_latency();
      alu_ops();
      bypass_chain();
      branch_resolve();
      external_flush();
      back_pressure();
      $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

   initial begin
      #(TEST_CYCLES * 4 * 8);
      $display("Timeout, the tests did not finish in time");
      $display("Testbench failed");
      $finish;
   end

endmodule

// File: tb_clkgen.sv
/*
 * Testbench clock and reset
 * 8 ns clock, active low reset held for 8 cycles
 */

module tb_clkgen (
   output logic o_clk,
   output logic o_rst_n
);

   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      o_clk   = 1'b0;
      o_rst_n = 1'b0;
      forever #4 o_clk = ~o_clk;
   end

   initial begin
      repeat (8) @(posedge o_clk);
      #1 o_rst_n = 1'b1;                           // Release off the edge
   end

endmodule

// File: exu_top.sv
/*
 * Integer execute stage top level
 * Operand select, ALU and branch resolve, then the result queue with
 * credit flow control toward the issuer and the consumer
 */

module exu_top (
   input  logic               i_clk,
   input  logic               i_rst_n,
   input  logic               i_issue_valid,
   input  exu_pkg::alu_op_e   i_issue_op,
   input  exu_pkg::tag_t      i_issue_tag,
   input  exu_pkg::pc_t       i_issue_pc,
   input  exu_pkg::boff_t     i_issue_boff,
   input  logic               i_issue_pred_taken,
   input  exu_pkg::src_sel_e  i_rs1_sel,
   input  exu_pkg::src_sel_e  i_rs2_sel,
   input  exu_pkg::word_t     i_gpr_rs1,
   input  exu_pkg::word_t     i_gpr_rs2,
   input  exu_pkg::word_t     i_imm,
   input  exu_pkg::word_t     i_wb_data,
   input  logic               i_flush_lower,    // Flush from the trap unit
   input  exu_pkg::pc_t       i_flush_path,
   output logic               o_res_valid,
   output exu_pkg::word_t     o_res_data,
   output exu_pkg::tag_t      o_res_tag,
   output exu_pkg::credit_t   o_issue_credit,
   input  logic               i_res_credit,
   output logic               o_flush,
   output exu_pkg::pc_t       o_flush_path
);

   uop_if u_uop_if ();
   res_if u_res_if ();

   exu_decode u_decode (
      .i_clk              (i_clk),
      .i_rst_n            (i_rst_n),
      .i_issue_valid      (i_issue_valid),
      .i_issue_op         (i_issue_op),
      .i_issue_tag        (i_issue_tag),
      .i_issue_pc         (i_issue_pc),
      .i_issue_boff       (i_issue_boff),
      .i_issue_pred_taken (i_issue_pred_taken),
      .i_rs1_sel          (i_rs1_sel),
      .i_rs2_sel          (i_rs2_sel),
      .i_gpr_rs1          (i_gpr_rs1),
      .i_gpr_rs2          (i_gpr_rs2),
      .i_imm              (i_imm),
      .i_wb_data          (i_wb_data),
      .uop                (u_uop_if.dec),
      .res                (u_res_if.byp)
   );

   exu_execute u_execute (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .uop     (u_uop_if.exe),
      .res     (u_res_if.exe)
   );

   exu_result u_result (
      .i_clk          (i_clk),
      .i_rst_n        (i_rst_n),
      .res            (u_res_if.res),
      .i_flush_lower  (i_flush_lower),
      .i_flush_path   (i_flush_path),
      .i_res_credit   (i_res_credit),
      .o_res_valid    (o_res_valid),
      .o_res_data     (o_res_data),
      .o_res_tag      (o_res_tag),
      .o_issue_credit (o_issue_credit),
      .o_flush        (o_flush),
      .o_flush_path   (o_flush_path)
   );

endmodule

// File: exu_result.sv
/*
 * Execute stage result drain and flush
 * Arbitrates the external and branch flush, queues results under result
 * credits and sums the issue credits handed back each cycle
 */

module exu_result (
   input  logic              i_clk,
   input  logic              i_rst_n,
   res_if.res                res,
   input  logic              i_flush_lower,
   input  exu_pkg::pc_t      i_flush_path,
   input  logic              i_res_credit,
   output logic              o_res_valid,
   output exu_pkg::word_t    o_res_data,
   output exu_pkg::tag_t     o_res_tag,
   output exu_pkg::credit_t  o_issue_credit,
   output logic              o_flush,
   output exu_pkg::pc_t      o_flush_path
);

   logic               flush_br;
   logic               flush;
   logic               push;
   logic               pop;
   logic               x_kill;                   // Execute register killed
   exu_pkg::qptr_t     wr_ptr;
   exu_pkg::qptr_t     rd_ptr;
   exu_pkg::qcnt_t     count;
   exu_pkg::credit_t   res_cred;

   exu_pkg::word_t     data_mem [exu_pkg::QUEUE_DEPTH];
   exu_pkg::tag_t      tag_mem  [exu_pkg::QUEUE_DEPTH];

   assign flush_br = res.valid & res.mispredict;
   assign flush    = i_flush_lower | flush_br;
   assign res.flush = flush;
   assign o_flush   = flush;

   // External flush is older and wins
   assign o_flush_path = ({31{ i_flush_lower           }} & i_flush_path) |
                         ({31{~i_flush_lower & flush_br}} & res.path    );

   assign push   = res.valid & ~i_flush_lower;    // Mispredicting branch still retires
   assign x_kill = res.valid &  i_flush_lower;
   assign pop    = (count != '0) & (res_cred != '0);

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         res_cred <= exu_pkg::credit_t'(exu_pkg::RESULT_CREDITS);
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count    <= count + exu_pkg::qcnt_t'(push) - exu_pkg::qcnt_t'(pop);
         res_cred <= res_cred - exu_pkg::credit_t'(pop) + exu_pkg::credit_t'(i_res_credit);
      end
   end

   always_ff @(posedge i_clk) begin
      if (push) begin
         data_mem[wr_ptr] <= res.data;
         tag_mem[wr_ptr]  <= res.tag;
      end
   end

   assign o_res_valid = pop;                      // Consumed in the same cycle
   assign o_res_data  = data_mem[rd_ptr];
   assign o_res_tag   = tag_mem[rd_ptr];

   // One per pop plus every instruction dropped by a flush
   assign o_issue_credit = exu_pkg::credit_t'(pop) +
                           exu_pkg::credit_t'(res.kill_cnt) +
                           exu_pkg::credit_t'(x_kill);

endmodule

// File: exu_execute.sv
/*
 * Execute stage ALU and branch resolve
 * Computes the result of the instruction in the D-to-X register, resolves
 * branches and jumps against their prediction and holds the X-to-R register
 */

module exu_execute (
   input  logic  i_clk,
   input  logic  i_rst_n,
   uop_if.exe    uop,
   res_if.exe    res
);

   exu_pkg::uop_t   u;
   logic [4:0]      shamt;
   exu_pkg::word_t  alu_res;
   exu_pkg::word_t  x_res;
   logic            is_br;
   logic            taken;
   logic            misp_d;
   exu_pkg::pc_t    seq_pc;
   exu_pkg::pc_t    target;
   exu_pkg::pc_t    next_pc;

   logic            valid_q;
   logic            misp_q;
   exu_pkg::word_t  data_q;
   exu_pkg::tag_t   tag_q;
   exu_pkg::pc_t    path_q;

   assign u     = uop.uop;
   assign shamt = u.opb[4:0];

   always_comb begin
      case (u.op)
         exu_pkg::ADD:  alu_res = u.opa + u.opb;
         exu_pkg::SUB:  alu_res = u.opa - u.opb;
         exu_pkg::AND:  alu_res = u.opa & u.opb;
         exu_pkg::OR:   alu_res = u.opa | u.opb;
         exu_pkg::XOR:  alu_res = u.opa ^ u.opb;
         exu_pkg::SLL:  alu_res = u.opa << shamt;
         exu_pkg::SRL:  alu_res = u.opa >> shamt;
         exu_pkg::SRA:  alu_res = $signed(u.opa) >>> shamt;
         exu_pkg::SLT:  alu_res = exu_pkg::word_t'($signed(u.opa) < $signed(u.opb));
         exu_pkg::SLTU: alu_res = exu_pkg::word_t'(u.opa < u.opb);
         default:       alu_res = '0;         // Branches take the pc path
      endcase
   end

   always_comb begin
      is_br = 1'b1;
      case (u.op)
         exu_pkg::BEQ: taken = (u.opa == u.opb);
         exu_pkg::BNE: taken = (u.opa != u.opb);
         exu_pkg::BLT: taken = ($signed(u.opa) < $signed(u.opb));
         exu_pkg::BGE: taken = ($signed(u.opa) >= $signed(u.opb));
         exu_pkg::JAL: taken = 1'b1;
         default: begin
            is_br = 1'b0;
            taken = 1'b0;
         end
      endcase
   end

   assign seq_pc  = u.pc + 31'd2;                 // Four bytes on
   assign target  = u.pc + {{19{u.boff[11]}}, u.boff};
   assign next_pc = taken ? target : seq_pc;
   assign misp_d  = is_br & (taken != u.pred_taken);

   // Link address for JAL, resolved next pc for conditional branches
   assign x_res = (u.op == exu_pkg::JAL) ? {seq_pc, 1'b0} :
                  is_br                  ? {next_pc, 1'b0} : alu_res;

   assign uop.x_data = x_res;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         valid_q <= 1'b0;
         misp_q  <= 1'b0;
      end else begin
         valid_q <= uop.valid & ~res.flush;     // Younger than the flush source
         misp_q  <= uop.valid & ~res.flush & misp_d;
      end
   end

   always_ff @(posedge i_clk) begin
      if (uop.valid) begin
         data_q <= x_res;
         tag_q  <= u.tag;
         path_q <= next_pc;                      // Correct path either way
      end
   end

   assign res.valid      = valid_q;
   assign res.mispredict = misp_q;
   assign res.data       = data_q;
   assign res.tag        = tag_q;
   assign res.path       = path_q;

endmodule

// File: exu_decode.sv
/*
 * Execute stage operand select
 * Picks both operands from the register file, immediate, pc or one of three
 * bypass points and holds the issued instruction in the D-to-X register
 */

module exu_decode (
   input  logic               i_clk,
   input  logic               i_rst_n,
   input  logic               i_issue_valid,
   input  exu_pkg::alu_op_e   i_issue_op,
   input  exu_pkg::tag_t      i_issue_tag,
   input  exu_pkg::pc_t       i_issue_pc,
   input  exu_pkg::boff_t     i_issue_boff,
   input  logic               i_issue_pred_taken,
   input  exu_pkg::src_sel_e  i_rs1_sel,
   input  exu_pkg::src_sel_e  i_rs2_sel,
   input  exu_pkg::word_t     i_gpr_rs1,
   input  exu_pkg::word_t     i_gpr_rs2,
   input  exu_pkg::word_t     i_imm,
   input  exu_pkg::word_t     i_wb_data,
   uop_if.dec                 uop,
   res_if.byp                 res
);

   logic           valid_q;
   exu_pkg::uop_t  uop_d;
   exu_pkg::uop_t  uop_q;
   logic           kill_q;                        // Decode register content dropped
   logic           kill_issue;                    // Issue sampled during flush

   function automatic exu_pkg::word_t pick_operand(
      input exu_pkg::src_sel_e sel,
      input exu_pkg::word_t    gpr
   );
      exu_pkg::word_t val;
      case (sel)
         exu_pkg::GPR:    val = gpr;
         exu_pkg::IMM:    val = i_imm;
         exu_pkg::PC:     val = {i_issue_pc, 1'b0};
         exu_pkg::BYP_X:  val = uop.x_data;
         exu_pkg::BYP_R:  val = res.data;
         exu_pkg::BYP_WB: val = i_wb_data;
         default:         val = gpr;
      endcase
      return val;
   endfunction

   always_comb begin
      uop_d.op         = i_issue_op;
      uop_d.opa        = pick_operand(i_rs1_sel, i_gpr_rs1);
      uop_d.opb        = pick_operand(i_rs2_sel, i_gpr_rs2);
      uop_d.pc         = i_issue_pc;
      uop_d.boff       = i_issue_boff;
      uop_d.pred_taken = i_issue_pred_taken;
      uop_d.tag        = i_issue_tag;
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= i_issue_valid & ~res.flush;   // Issue dropped in flush cycle
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_issue_valid) begin
         uop_q <= uop_d;
      end
   end

   assign kill_q     = res.flush & valid_q;
   assign kill_issue = res.flush & i_issue_valid;

   assign res.kill_cnt = {1'b0, kill_q} + {1'b0, kill_issue};  // Credits owed back

   assign uop.valid = valid_q;
   assign uop.uop   = uop_q;

endmodule

// File: exu_if.sv
/*
 * Internal links of the execute stage
 * uop_if carries the decoded instruction into the ALU and the X bypass back,
 * res_if carries the execute register to the result block and the flush back
 */

interface uop_if;

   logic            valid;                        // Decode register holds an instruction
   exu_pkg::uop_t   uop;
   exu_pkg::word_t  x_data;                       // ALU result of that instruction

   modport dec (
      output valid,
      output uop,
      input  x_data
   );

   modport exe (
      input  valid,
      input  uop,
      output x_data
   );

endinterface

interface res_if;

   logic            valid;                        // Execute register holds a result
   exu_pkg::word_t  data;
   exu_pkg::tag_t   tag;
   logic            mispredict;
   exu_pkg::pc_t    path;                         // Redirect for a mispredict
   logic            flush;                        // Kill the younger stages
   logic [1:0]      kill_cnt;                     // Decode kills this cycle

   modport exe (output valid, data, tag, mispredict, path, input flush);

   modport res (input valid, data, tag, mispredict, path, kill_cnt, output flush);

   modport byp (input data, flush, output kill_cnt);

endinterface

// File: exu_pkg.sv
/*
 * Integer execute stage package
 * Data widths, credit counts, opcode and operand source encodings
 * and the record of one issued instruction
 */
package exu_pkg;

   localparam int XLEN           = 32;           // Data width
   localparam int TAG_W          = 4;            // Issuer tag width
   localparam int ISSUE_CREDITS  = 4;            // Held by the issuer after reset
   localparam int RESULT_CREDITS = 2;            // Held by the stage after reset
   localparam int QUEUE_DEPTH    = 4;            // Same as ISSUE_CREDITS so no overflow
   localparam int QPTR_W         = $clog2(QUEUE_DEPTH);
   localparam int QCNT_W         = QPTR_W + 1;   // Counts 0 to QUEUE_DEPTH
   localparam int CREDIT_W       = 3;            // Returned credit count

   typedef logic [XLEN-1:0]     word_t;
   typedef logic [31:1]         pc_t;            // Halfword program counter
   typedef logic [11:0]         boff_t;          // Branch offset in halfwords
   typedef logic [TAG_W-1:0]    tag_t;
   typedef logic [CREDIT_W-1:0] credit_t;
   typedef logic [QPTR_W-1:0]   qptr_t;
   typedef logic [QCNT_W-1:0]   qcnt_t;

   typedef enum logic [3:0] {
      ADD  = 4'd0,
      SUB  = 4'd1,
      AND  = 4'd2,
      OR   = 4'd3,
      XOR  = 4'd4,
      SLL  = 4'd5,
      SRL  = 4'd6,
      SRA  = 4'd7,
      SLT  = 4'd8,
      SLTU = 4'd9,
      BEQ  = 4'd10,
      BNE  = 4'd11,
      BLT  = 4'd12,
      BGE  = 4'd13,
      JAL  = 4'd14
   } alu_op_e;

   // Operand source, the three bypass points are youngest first
   typedef enum logic [2:0] {
      GPR    = 3'd0,
      IMM    = 3'd1,
      PC     = 3'd2,
      BYP_X  = 3'd3,                              // ALU output of the X stage
      BYP_R  = 3'd4,                              // Execute register result
      BYP_WB = 3'd5                               // Write-back data
   } src_sel_e;

   typedef struct packed {
      alu_op_e op;
      word_t   opa;
      word_t   opb;
      pc_t     pc;
      boff_t   boff;
      logic    pred_taken;                        // Predicted taken by fetch
      tag_t    tag;
   } uop_t;

endpackage
